// ==== Bender.yml ====
package:
  name: eth_rx

sources:
  - hdl/eth_rx_pkg.sv
  - hdl/mac_recv.sv
  - hdl/ip_recv.sv
  - hdl/udp_recv.sv
  - hdl/eth_rx_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/eth_rx_tb.sv

// ==== eth_rx.f ====
+incdir+verif
hdl/eth_rx_pkg.sv
hdl/mac_recv.sv
hdl/ip_recv.sv
hdl/udp_recv.sv
hdl/eth_rx_top.sv
verif/eth_rx_tb.sv

// ==== hdl/eth_rx_pkg.sv ====
// ethernet receive definitions
package eth_rx_pkg;

  // one byte of the receive stream
  typedef logic [7:0] byte_t;

  // ethernet station address
  typedef logic [47:0] mac_addr_t;

  // ipv4 address
  typedef logic [31:0] ip_addr_t;

  // udp port number
  typedef logic [15:0] port_t;

  // byte index inside one layer, also used for lengths
  // 11 bits cover a full 1500 byte payload plus headers
  typedef logic [10:0] byte_count_t;

  // ethertype carried in frame bytes 12 and 13
  localparam logic [15:0] ethertype_ipv4 = 16'h0800;

  // ip protocol number for udp
  localparam byte_t ip_proto_udp = 8'd17;

  // version 4, five 32-bit words of header
  localparam byte_t ip_version_ihl = 8'h45;

  // dhcp replies land on the client port
  localparam port_t dhcp_client_port = 16'd68;

  // discovery traffic, lowest bit ignored so 1025 matches too
  localparam port_t discovery_port = 16'd1024;

  // header sizes per layer
  localparam byte_count_t eth_header_bytes = 11'd14;
  localparam byte_count_t ip_header_bytes = 11'd20;
  localparam byte_count_t udp_header_bytes = 11'd8;

  // all ones destination
  localparam mac_addr_t mac_broadcast = 48'hffff_ffff_ffff;

endpackage

// ==== hdl/eth_rx_top.sv ====
// ethernet udp receive path
`timescale 1ns/1ns

module eth_rx_top (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  rx_enable,
  input  eth_rx_pkg::byte_t     data,
  input  eth_rx_pkg::mac_addr_t local_mac,
  input  eth_rx_pkg::ip_addr_t  local_ip,
  output eth_rx_pkg::byte_t     payload_data,
  output logic                  payload_active,
  output logic                  dhcp_active,
  output eth_rx_pkg::port_t     to_port,
  output eth_rx_pkg::mac_addr_t dest_mac,
  output eth_rx_pkg::ip_addr_t  dest_ip,
  output eth_rx_pkg::port_t     dest_port,
  output logic                  dest_valid
);

  import eth_rx_pkg::*;

  // mac stage to ip stage
  logic      ip_enable;
  byte_t     ip_data;
  mac_addr_t remote_mac;
  logic      broadcast;

  // ip stage to udp stage
  logic      udp_enable;
  byte_t     udp_data;
  ip_addr_t  remote_ip;
  ip_addr_t  to_ip;

  // destination mac and ethertype filter, one clock of delay
  mac_recv u_mac_recv (
    .clock      (clock),
    .rst_n      (rst_n),
    .rx_enable  (rx_enable),
    .data       (data),
    .local_mac  (local_mac),
    .ip_enable  (ip_enable),
    .ip_data    (ip_data),
    .remote_mac (remote_mac),
    .broadcast  (broadcast)
  );

  // ipv4 header check, one more clock of delay
  ip_recv u_ip_recv (
    .clock      (clock),
    .rst_n      (rst_n),
    .ip_enable  (ip_enable),
    .ip_data    (ip_data),
    .udp_enable (udp_enable),
    .udp_data   (udp_data),
    .remote_ip  (remote_ip),
    .to_ip      (to_ip)
  );

  // port rules and payload marking
  udp_recv u_udp_recv (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .udp_enable            (udp_enable),
    .broadcast             (broadcast),
    .udp_data              (udp_data),
    .to_ip                 (to_ip),
    .remote_ip             (remote_ip),
    .local_ip              (local_ip),
    .remote_mac            (remote_mac),
    .active                (payload_active),
    .dhcp_active           (dhcp_active),
    .payload_data          (payload_data),
    .to_port               (to_port),
    .udp_destination_ip    (dest_ip),
    .udp_destination_mac   (dest_mac),
    .udp_destination_port  (dest_port),
    .udp_destination_valid (dest_valid)
  );

endmodule

// ==== hdl/ip_recv.sv ====
// ipv4 header parser
`timescale 1ns/1ns

module ip_recv (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 ip_enable,
  input  eth_rx_pkg::byte_t    ip_data,
  output logic                 udp_enable,
  output eth_rx_pkg::byte_t    udp_data,
  output eth_rx_pkg::ip_addr_t remote_ip,
  output eth_rx_pkg::ip_addr_t to_ip
);

  import eth_rx_pkg::*;

  // header walk, pass the datagram on, or wait out a bad packet
  typedef enum logic [1:0] {
    st_header,
    st_pass,
    st_done
  } state_t;

  state_t      state;
  byte_count_t byte_no;
  logic        version_bad;
  logic        proto_bad;

  // byte 0 holds version and ihl, options are not supported
  assign version_bad = (byte_no == 11'd0) && (ip_data != ip_version_ihl);
  // byte 9 holds the protocol number
  assign proto_bad = (byte_no == 11'd9) && (ip_data != ip_proto_udp);

  // address capture
  always_ff @(posedge clock) begin
    if (ip_enable && state == st_header) begin
      if (byte_no >= 11'd12 && byte_no < 11'd16) begin
        // source address, bytes 12 to 15
        remote_ip <= {remote_ip[23:0], ip_data};
      end else if (byte_no >= 11'd16 && byte_no < 11'd20) begin
        // destination address, bytes 16 to 19
        // judged later by the udp stage
        to_ip <= {to_ip[23:0], ip_data};
      end
    end
  end

  // datagram bytes to the udp stage
  always_ff @(posedge clock) begin
    udp_data <= ip_data;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state      <= st_header;
      byte_no    <= '0;
      udp_enable <= 1'b0;
    end else begin
      // registered enable, ip byte 20 shows one clock later
      udp_enable <= ip_enable && (state == st_pass);
      if (!ip_enable) begin
        state   <= st_header;
        byte_no <= '0;
      end else if (state == st_header) begin
        byte_no <= byte_no + 11'd1;
        if (version_bad || proto_bad) begin
          // hold here until the mac stage ends the frame
          state <= st_done;
        end else if (byte_no == byte_count_t'(ip_header_bytes - 11'd1)) begin
          state <= st_pass;
        end
      end
    end
  end

endmodule

// ==== hdl/mac_recv.sv ====
// ethernet header filter
`timescale 1ns/1ns

module mac_recv (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  rx_enable,
  input  eth_rx_pkg::byte_t     data,
  input  eth_rx_pkg::mac_addr_t local_mac,
  output logic                  ip_enable,
  output eth_rx_pkg::byte_t     ip_data,
  output eth_rx_pkg::mac_addr_t remote_mac,
  output logic                  broadcast
);

  import eth_rx_pkg::*;

  // header walk, then either forward the rest or sit out the frame
  typedef enum logic [1:0] {
    st_header,
    st_pass,
    st_drop
  } state_t;

  state_t      state;
  byte_count_t byte_no;

  // destination address as it arrives, bytes 0 to 5
  mac_addr_t   dest_shift;
  // upper ethertype byte, frame byte 12
  byte_t       type_hi;
  logic        addr_ok;

  // accept our own address or the broadcast address
  assign addr_ok = (dest_shift == local_mac) || (dest_shift == mac_broadcast);

  // header fields, captured while the counter walks the header
  always_ff @(posedge clock) begin
    if (rx_enable && state == st_header) begin
      if (byte_no < 11'd6) begin
        dest_shift <= {dest_shift[39:0], data};
      end else if (byte_no < 11'd12) begin
        // source address becomes the reply address
        remote_mac <= {remote_mac[39:0], data};
      end else if (byte_no == 11'd12) begin
        type_hi <= data;
      end
    end
  end

  // byte stream to the ip stage, one clock behind data
  always_ff @(posedge clock) begin
    ip_data <= data;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state     <= st_header;
      byte_no   <= '0;
      broadcast <= 1'b0;
      ip_enable <= 1'b0;
    end else begin
      // ip stage sees byte 14 onward, until the frame gate drops
      ip_enable <= rx_enable && (state == st_pass);
      if (!rx_enable) begin
        // gap between frames, rearm for the next header
        state   <= st_header;
        byte_no <= '0;
      end else if (state == st_header) begin
        byte_no <= byte_no + 11'd1;
        // last header byte, decide on address and ethertype
        if (byte_no == byte_count_t'(eth_header_bytes - 11'd1)) begin
          broadcast <= (dest_shift == mac_broadcast);
          if (addr_ok && ({type_hi, data} == ethertype_ipv4)) begin
            state <= st_pass;
          end else begin
            state <= st_drop;
          end
        end
      end
    end
  end

endmodule

// ==== hdl/udp_recv.sv ====
// udp header parser and payload gate
`timescale 1ns/1ns

module udp_recv (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  udp_enable,
  input  logic                  broadcast,
  input  eth_rx_pkg::byte_t     udp_data,
  input  eth_rx_pkg::ip_addr_t  to_ip,
  input  eth_rx_pkg::ip_addr_t  remote_ip,
  input  eth_rx_pkg::ip_addr_t  local_ip,
  input  eth_rx_pkg::mac_addr_t remote_mac,
  output logic                  active,
  output logic                  dhcp_active,
  output eth_rx_pkg::byte_t     payload_data,
  output eth_rx_pkg::port_t     to_port,
  output eth_rx_pkg::ip_addr_t  udp_destination_ip,
  output eth_rx_pkg::mac_addr_t udp_destination_mac,
  output eth_rx_pkg::port_t     udp_destination_port,
  output logic                  udp_destination_valid
);

  import eth_rx_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_port,
    st_verify,
    st_payload,
    st_done
  } state_t;

  state_t      state;
  byte_count_t byte_no;
  byte_count_t packet_len;
  byte_t       len_hi;
  port_t       remote_port;
  logic        dhcp_flag;

  // payload goes straight through, the state only marks it
  assign payload_data = udp_data;
  assign active       = udp_enable && (state == st_payload) && !dhcp_flag;
  assign dhcp_active  = udp_enable && (state == st_payload) && dhcp_flag;

  // header fields and reply address
  always_ff @(posedge clock) begin
    if (udp_enable) begin
      if (state == st_idle) begin
        remote_port[15:8] <= udp_data;
      end else if (state == st_port) begin
        remote_port[7:0] <= udp_data;
      end else if (state == st_verify) begin
        case (byte_no)
          11'd2: to_port[15:8] <= udp_data;
          11'd3: to_port[7:0] <= udp_data;
          11'd4: len_hi <= udp_data;
          11'd5: packet_len <= {len_hi[2:0], udp_data};
          11'd6: begin
            // loaded one byte early so it is valid alongside the strobe
            udp_destination_mac  <= remote_mac;
            udp_destination_ip   <= remote_ip;
            udp_destination_port <= remote_port;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state                 <= st_idle;
      byte_no               <= '0;
      dhcp_flag             <= 1'b0;
      udp_destination_valid <= 1'b0;
    end else begin
      // single cycle notice, high while byte 7 is on udp_data
      udp_destination_valid <= 1'b0;
      if (!udp_enable) begin
        state   <= st_idle;
        byte_no <= '0;
      end else begin
        if (state != st_done) begin
          byte_no <= byte_no + 11'd1;
        end
        case (state)
          st_idle: begin
            dhcp_flag <= 1'b0;
            state     <= st_port;
          end
          st_port: state <= st_verify;
          st_verify: begin
            if (byte_no == 11'd4) begin
              // dhcp first, then discovery broadcast, then unicast to us
              if (to_port == dhcp_client_port) begin
                dhcp_flag <= 1'b1;
              end else if (broadcast) begin
                if (to_port[15:1] != discovery_port[15:1]) state <= st_done;
              end else if (to_ip != local_ip) begin
                state <= st_done;
              end
            end
            // length shorter than the header itself
            if (byte_no == 11'd5 && {len_hi, udp_data} < 16'(udp_header_bytes)) begin
              state <= st_done;
            end
            if (byte_no == 11'd6) udp_destination_valid <= 1'b1;
            // checksum skipped, payload starts with byte 8
            if (byte_no == 11'd7) begin
              state <= (packet_len == udp_header_bytes) ? st_done : st_payload;
            end
          end
          st_payload: begin
            // stop at the udp length so ethernet padding is not passed on
            if (byte_no == packet_len - 11'd1) state <= st_done;
          end
          default: state <= st_done;
        endcase
      end
    end
  end

endmodule

// ==== verif/eth_rx_tests.svh ====
// directed receive tests

// frame that must leave no trace at the outputs
task automatic expect_dropped(input string name);
  settle();
  if (active_q.size() != 0) report_mismatch({name, " active"}, 0, active_q.size());
  if (dhcp_q.size() != 0) report_mismatch({name, " dhcp"}, 0, dhcp_q.size());
  if (valid_count != 0) report_mismatch({name, " dest_valid"}, 0, valid_count);
endtask

task automatic test_reset();
  int start;
  int i;
  start = errors;
  make_payload(12);
  build_frame(station_mac, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
              src_ip, station_ip, 16'd4000, 16'd4001);
  // frame stopped inside its payload by a reset, gate still open
  for (i = 0; i < 50; i++) begin
    @(negedge clock);
    rx_enable = 1'b1;
    data = frame_q[i];
  end
  @(negedge clock);
  if (payload_active !== 1'b1) report_mismatch("reset payload before reset", 1, payload_active);
  rst_n = 1'b0;
  // one clock of reset with rx_enable high must clear the payload lines
  @(negedge clock);
  if (payload_active !== 1'b0) report_mismatch("reset payload_active in reset", 0, payload_active);
  if (dhcp_active !== 1'b0) report_mismatch("reset dhcp_active in reset", 0, dhcp_active);
  if (dest_valid !== 1'b0) report_mismatch("reset dest_valid in reset", 0, dest_valid);
  apply_reset();
  clear_capture();
  repeat (10) @(negedge clock);
  if (payload_active !== 1'b0) report_mismatch("reset payload_active", 0, payload_active);
  if (dhcp_active !== 1'b0) report_mismatch("reset dhcp_active", 0, dhcp_active);
  if (dest_valid !== 1'b0) report_mismatch("reset dest_valid", 0, dest_valid);
  expect_dropped("reset");
  finish_test("reset", start);
endtask

task automatic test_unicast();
  int start;
  start = errors;
  clear_capture();
  make_payload(16);
  build_frame(station_mac, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
              src_ip, station_ip, 16'd5000, 16'd6000);
  expect_payload();
  send_frame(0, 0);
  settle();
  check_stream("unicast", 1'b0);
  if (valid_count != 1) report_mismatch("unicast dest_valid", 1, valid_count);
  if (cap_mac !== src_mac) report_mismatch("unicast dest_mac", src_mac, cap_mac);
  if (cap_ip !== src_ip) report_mismatch("unicast dest_ip", src_ip, cap_ip);
  if (cap_port !== 16'd5000) report_mismatch("unicast dest_port", 16'd5000, cap_port);
  if (cap_to_port !== 16'd6000) report_mismatch("unicast to_port", 16'd6000, cap_to_port);
  finish_test("unicast", start);
endtask

task automatic test_filtering();
  int start;
  start = errors;
  make_payload(8);
  clear_capture();
  build_frame(station_mac ^ 48'h1, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
              src_ip, station_ip, 16'd5000, 16'd6000);
  send_frame(0, 0);
  expect_dropped("filtering mac");
  // arp ethertype
  build_frame(station_mac, 16'h0806, ip_version_ihl, ip_proto_udp,
              src_ip, station_ip, 16'd5000, 16'd6000);
  send_frame(0, 0);
  expect_dropped("filtering ethertype");
  // header with options
  build_frame(station_mac, ethertype_ipv4, 8'h46, ip_proto_udp,
              src_ip, station_ip, 16'd5000, 16'd6000);
  send_frame(0, 0);
  expect_dropped("filtering ihl");
  // tcp
  build_frame(station_mac, ethertype_ipv4, ip_version_ihl, 8'd6,
              src_ip, station_ip, 16'd5000, 16'd6000);
  send_frame(0, 0);
  expect_dropped("filtering protocol");
  build_frame(station_mac, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
              src_ip, station_ip ^ 32'h1, 16'd5000, 16'd6000);
  send_frame(0, 0);
  expect_dropped("filtering ip");
  finish_test("filtering", start);
endtask

task automatic test_broadcast();
  int start;
  start = errors;
  clear_capture();
  // three frames back to back, foreign ip on all of them
  make_payload(10);
  build_frame(mac_broadcast, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
              src_ip, 32'hc0a8_01ff, 16'd7000, 16'd1024);
  expect_payload();
  send_frame(0, 0);
  make_payload(6);
  build_frame(mac_broadcast, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
              src_ip, 32'hc0a8_01ff, 16'd7001, 16'd1025);
  expect_payload();
  send_frame(0, 0);
  make_payload(9);
  build_frame(mac_broadcast, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
              src_ip, 32'hc0a8_01ff, 16'd7002, 16'd1026);
  send_frame(0, 0);
  settle();
  check_stream("broadcast", 1'b0);
  if (valid_count != 2) report_mismatch("broadcast dest_valid", 2, valid_count);
  if (cap_to_port !== 16'd1025) report_mismatch("broadcast to_port", 16'd1025, cap_to_port);
  if (cap_port !== 16'd7001) report_mismatch("broadcast dest_port", 16'd7001, cap_port);
  finish_test("broadcast", start);
endtask

task automatic test_dhcp();
  int start;
  start = errors;
  clear_capture();
  make_payload(20);
  build_frame(station_mac, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
              src_ip, 32'h0a00_0001, 16'd67, dhcp_client_port);
  expect_payload();
  send_frame(0, 0);
  settle();
  check_stream("dhcp", 1'b1);
  if (valid_count != 1) report_mismatch("dhcp dest_valid", 1, valid_count);
  finish_test("dhcp", start);
endtask

task automatic test_length();
  int start;
  int n;
  int len;
  int pad;
  start = errors;
  for (n = 0; n < 8; n++) begin
    len = 1 + ($urandom % 64);
    pad = $urandom % 16;
    clear_capture();
    make_payload(len);
    build_frame(station_mac, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
                src_ip, station_ip, 16'd5000, 16'd6000);
    expect_payload();
    // padding after the datagram must not reach the payload lines
    send_frame(0, pad);
    settle();
    check_stream($sformatf("length %0d pad %0d", len, pad), 1'b0);
  end
  finish_test("length", start);
endtask

task automatic test_truncation();
  int start;
  int k;
  int cut;
  start = errors;
  for (k = 0; k < 2; k++) begin
    // first cut lands in the mac header, second in the ip header
    cut = (k == 0) ? 9 : 30;
    clear_capture();
    make_payload(14);
    build_frame(station_mac, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
                src_ip, station_ip, 16'd5000, 16'd6000);
    send_frame(cut, 0);
    make_payload(11);
    build_frame(station_mac, ethertype_ipv4, ip_version_ihl, ip_proto_udp,
                src_ip, station_ip, 16'd5100, 16'd6100);
    expect_payload();
    send_frame(0, 0);
    settle();
    check_stream($sformatf("truncation at %0d", cut), 1'b0);
    if (valid_count != 1) report_mismatch("truncation dest_valid", 1, valid_count);
  end
  finish_test("truncation", start);
endtask

// ==== verif/eth_rx_tb.sv ====
// ethernet receive testbench
`timescale 1ns/1ns

module eth_rx_tb;

  import eth_rx_pkg::*;

  // longest frame built by the tests: headers, 64 payload bytes, 15 padding bytes
  localparam int max_frame_bytes = 42 + 64 + 15;
  // upper bound on frames sent over the whole run
  localparam int frame_budget = 24;
  localparam int clock_period = 100;
  localparam int watchdog_ns = (frame_budget * max_frame_bytes + 200) * clock_period;

  // far end of the link
  localparam mac_addr_t src_mac = 48'h02_00_5e_10_20_30;
  localparam ip_addr_t  src_ip = 32'hc0a8_010a;
  // this station
  localparam mac_addr_t station_mac = 48'h02_00_00_aa_bb_cc;
  localparam ip_addr_t  station_ip = 32'hc0a8_0164;

  logic      clock;
  logic      rst_n;
  logic      rx_enable;
  byte_t     data;
  mac_addr_t local_mac;
  ip_addr_t  local_ip;
  byte_t     payload_data;
  logic      payload_active;
  logic      dhcp_active;
  port_t     to_port;
  mac_addr_t dest_mac;
  ip_addr_t  dest_ip;
  port_t     dest_port;
  logic      dest_valid;

  // frame under construction, its payload, and what should come out
  byte_t frame_q[$];
  byte_t payload_q[$];
  byte_t expected_q[$];
  // collected by the monitor
  byte_t active_q[$];
  byte_t dhcp_q[$];
  int    valid_count;
  int    order_errors;
  logic  was_active;
  logic  was_valid;
  mac_addr_t cap_mac;
  ip_addr_t  cap_ip;
  port_t     cap_port;
  port_t     cap_to_port;

  int errors;
  int tests_passed;
  int tests_failed;
  int seed;

  eth_rx_top dut (
    .clock          (clock),
    .rst_n          (rst_n),
    .rx_enable      (rx_enable),
    .data           (data),
    .local_mac      (local_mac),
    .local_ip       (local_ip),
    .payload_data   (payload_data),
    .payload_active (payload_active),
    .dhcp_active    (dhcp_active),
    .to_port        (to_port),
    .dest_mac       (dest_mac),
    .dest_ip        (dest_ip),
    .dest_port      (dest_port),
    .dest_valid     (dest_valid)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the DUT stopped producing results", watchdog_ns);
    $display("Verification failed");
    $finish;
  end

  // payload collection and reply address capture
  always @(posedge clock) begin
    if (payload_active) active_q.push_back(payload_data);
    if (dhcp_active) dhcp_q.push_back(payload_data);
    if (dest_valid) begin
      valid_count++;
      cap_mac = dest_mac;
      cap_ip = dest_ip;
      cap_port = dest_port;
      cap_to_port = to_port;
    end
    // first payload byte must come right after the notice
    if ((payload_active || dhcp_active) && !was_active && !was_valid) order_errors++;
    was_active = payload_active || dhcp_active;
    was_valid = dest_valid;
  end

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("mismatch %s: expected 0x%0h actual 0x%0h", what, exp, act);
    errors++;
  endtask

  task automatic finish_test(input string name, input int start);
    if (errors == start) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d mismatches", name, errors - start);
      tests_failed++;
    end
  endtask

  task automatic apply_reset();
    @(negedge clock);
    rst_n = 1'b0;
    rx_enable = 1'b0;
    repeat (4) @(negedge clock);
    rst_n = 1'b1;
  endtask

  task automatic clear_capture();
    active_q.delete();
    dhcp_q.delete();
    expected_q.delete();
    valid_count = 0;
    order_errors = 0;
    cap_mac = '0;
    cap_ip = '0;
    cap_port = '0;
    cap_to_port = '0;
  endtask

  // pipeline is two clocks deep, four covers the tail of any frame
  task automatic settle();
    repeat (4) @(negedge clock);
  endtask

  task automatic make_payload(input int len);
    int i;
    payload_q.delete();
    for (i = 0; i < len; i++) payload_q.push_back(byte_t'($urandom));
  endtask

  task automatic expect_payload();
    int i;
    for (i = 0; i < payload_q.size(); i++) expected_q.push_back(payload_q[i]);
  endtask

  task automatic build_frame(input mac_addr_t dst_mac, input logic [15:0] ethertype,
                             input byte_t ver_ihl, input byte_t proto,
                             input ip_addr_t from_ip, input ip_addr_t dst_ip,
                             input port_t from_port, input port_t dst_port);
    logic [15:0] udp_len;
    logic [15:0] ip_len;
    int i;
    udp_len = 16'(udp_header_bytes) + 16'(payload_q.size());
    ip_len = udp_len + 16'(ip_header_bytes);
    frame_q.delete();
    for (i = 5; i >= 0; i--) frame_q.push_back(dst_mac[i*8 +: 8]);
    for (i = 5; i >= 0; i--) frame_q.push_back(src_mac[i*8 +: 8]);
    frame_q.push_back(ethertype[15:8]);
    frame_q.push_back(ethertype[7:0]);
    // ipv4 header, tos zero
    frame_q.push_back(ver_ihl);
    frame_q.push_back(8'h00);
    frame_q.push_back(ip_len[15:8]);
    frame_q.push_back(ip_len[7:0]);
    // id, flags, fragment offset
    repeat (4) frame_q.push_back(8'h00);
    frame_q.push_back(8'd64);
    frame_q.push_back(proto);
    // header checksum not checked by the DUT
    repeat (2) frame_q.push_back(8'h00);
    for (i = 3; i >= 0; i--) frame_q.push_back(from_ip[i*8 +: 8]);
    for (i = 3; i >= 0; i--) frame_q.push_back(dst_ip[i*8 +: 8]);
    // udp header
    frame_q.push_back(from_port[15:8]);
    frame_q.push_back(from_port[7:0]);
    frame_q.push_back(dst_port[15:8]);
    frame_q.push_back(dst_port[7:0]);
    frame_q.push_back(udp_len[15:8]);
    frame_q.push_back(udp_len[7:0]);
    repeat (2) frame_q.push_back(8'h00);
    for (i = 0; i < payload_q.size(); i++) frame_q.push_back(payload_q[i]);
  endtask

  // cut of zero sends the whole frame, then pad bytes, then one idle clock
  task automatic send_frame(input int cut, input int pad);
    int n;
    int i;
    n = frame_q.size();
    if (cut > 0 && cut < n) n = cut;
    for (i = 0; i < n; i++) begin
      @(negedge clock);
      rx_enable = 1'b1;
      data = frame_q[i];
    end
    for (i = 0; i < pad; i++) begin
      @(negedge clock);
      rx_enable = 1'b1;
      data = byte_t'($urandom);
    end
    @(negedge clock);
    rx_enable = 1'b0;
    data = '0;
  endtask

  task automatic check_stream(input string name, input bit on_dhcp);
    byte_t got_q[$];
    int i;
    if (on_dhcp) got_q = dhcp_q;
    else got_q = active_q;
    if (got_q.size() != expected_q.size()) begin
      report_mismatch({name, " byte count"}, expected_q.size(), got_q.size());
    end else begin
      for (i = 0; i < expected_q.size(); i++) begin
        if (got_q[i] !== expected_q[i]) begin
          report_mismatch($sformatf("%s byte %0d", name, i), expected_q[i], got_q[i]);
          break;
        end
      end
    end
    // the other line stays quiet
    if (on_dhcp && active_q.size() != 0) report_mismatch({name, " active"}, 0, active_q.size());
    if (!on_dhcp && dhcp_q.size() != 0) report_mismatch({name, " dhcp"}, 0, dhcp_q.size());
    if (order_errors != 0) report_mismatch({name, " payload after notice"}, 0, order_errors);
  endtask

  `include "eth_rx_tests.svh"

  initial begin
    rst_n = 1'b0;
    rx_enable = 1'b0;
    data = '0;
    local_mac = station_mac;
    local_ip = station_ip;
    was_active = 1'b0;
    was_valid = 1'b0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    seed = 89;
    void'($urandom(seed));
    clear_capture();
    apply_reset();
    test_reset();
    test_unicast();
    test_filtering();
    test_broadcast();
    test_dhcp();
    test_length();
    test_truncation();
    $display("tests ok %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
